//--- logic/natv_params.svh
// --------------------------------------------------
// address map and field widths of the peripheral slice
// include wherever a width or slot value is needed
// --------------------------------------------------
`ifndef NATV_PARAMS_SVH
`define NATV_PARAMS_SVH

// native bus widths
`define NATV_ADDR_W 32
`define NATV_DATA_W 32
`define NATV_STRB_W 4

// register page in addr[31:24], slave slots in addr[15:8]
`define NATV_REG_PAGE  8'h10
`define NATV_GPIO_SLOT 8'h00
`define NATV_TIM0_SLOT 8'h20
`define NATV_TIM1_SLOT 8'h30

// peripheral field widths
`define NATV_GPIO_W 16
`define NATV_PSC_W  16

`endif

//--- logic/natv_pkg.sv
// --------------------------------------------------
// bus and timer types shared by the design and bench
// --------------------------------------------------
`default_nettype none

`include "natv_params.svh"

package natv_pkg;

  typedef logic [`NATV_ADDR_W-1:0] nmi_addr_t;
  typedef logic [`NATV_DATA_W-1:0] nmi_data_t;
  typedef logic [`NATV_STRB_W-1:0] nmi_strb_t;

  // bit 0 runs the counter, bit 1 lets the status flag reach irq
  typedef struct packed {
    logic irq_en;
    logic en;
  } tim_ctrl_t;

  // overlay the strobed bytes of wdata onto an old register value
  function automatic nmi_data_t byte_merge(input nmi_data_t old_val,
                                           input nmi_data_t wdata,
                                           input nmi_strb_t wstrb);
    nmi_data_t res;
    res = old_val;
    for (int i = 0; i < `NATV_STRB_W; i++) begin
      if (wstrb[i]) begin
        res[i*8+:8] = wdata[i*8+:8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- logic/nmi_if.sv
// --------------------------------------------------
// native memory interface between the cpu side and slaves
// wstrb of zero is a read, rdata valid only with ready
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface nmi_if;

  logic                valid;
  logic                ready;
  natv_pkg::nmi_addr_t addr;
  natv_pkg::nmi_data_t wdata;
  natv_pkg::nmi_strb_t wstrb;
  natv_pkg::nmi_data_t rdata;

  modport master(
    output valid, addr, wdata, wstrb,
    input  ready, rdata
  );

  modport slave(
    input  valid, addr, wdata, wstrb,
    output ready, rdata
  );

endinterface

`default_nettype wire

//--- logic/tim_if.sv
// --------------------------------------------------
// link between a timer register block and its counter
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "natv_params.svh"

interface tim_if;

  natv_pkg::tim_ctrl_t     ctrl;
  logic [`NATV_PSC_W-1:0]  psc;
  logic [31:0]             cmp;
  logic                    clr;
  logic [31:0]             cnt;
  logic                    match;

  modport regs(output ctrl, psc, cmp, clr, input cnt, match);
  modport core(input ctrl, psc, cmp, clr, output cnt, match);

endinterface

`default_nettype wire

//--- logic/timer_core.sv
// --------------------------------------------------
// prescaler and 32-bit counter with compare match
// one tick every psc+1 clocks while enabled
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "natv_params.svh"

module timer_core (
  input  logic clk_i,
  input  logic reset_i,
  tim_if.core  tim
);

  logic [`NATV_PSC_W-1:0] psc_cnt_q;
  logic [31:0]            cnt_q;
  logic                   match_q;
  logic                   tick;

  // >= keeps the prescaler from running the long way round when psc shrinks
  assign tick = tim.ctrl.en && (psc_cnt_q >= tim.psc);

  always_ff @(posedge clk_i) begin
    if (reset_i || tim.clr) begin
      psc_cnt_q <= '0;
      cnt_q     <= '0;
      match_q   <= 1'b0;
    end else begin
      match_q <= 1'b0;
      if (tick) begin
        psc_cnt_q <= '0;
        if (cnt_q == tim.cmp) begin
          cnt_q   <= '0;
          match_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 32'd1;
        end
      end else if (tim.ctrl.en) begin
        psc_cnt_q <= psc_cnt_q + 1'b1;
      end
      // disabled: both counters hold
    end
  end

  assign tim.cnt   = cnt_q;
  assign tim.match = match_q;

endmodule

`default_nettype wire

//--- logic/simple_timer.sv
// --------------------------------------------------
// timer register block on the native bus, holds the
// match flag and raises irq when irq enable is set
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "natv_params.svh"

module simple_timer (
  input  logic clk_i,
  input  logic reset_i,
  nmi_if.slave nmi,
  output logic irq_o
);

  tim_if u_tim_if ();

  natv_pkg::tim_ctrl_t    ctrl_q;
  logic [`NATV_PSC_W-1:0] psc_q;
  logic [31:0]            cmp_q;
  logic                   clr_q;
  logic                   flag_q;
  logic                   ready_q;
  logic                   accept;
  logic                   wr_en;
  natv_pkg::nmi_data_t    rdata_q;
  natv_pkg::nmi_data_t    rd_mux;
  natv_pkg::nmi_data_t    ctrl_merged;
  natv_pkg::nmi_data_t    psc_merged;
  natv_pkg::nmi_data_t    cmp_merged;

  assign accept = nmi.valid & ~ready_q;
  assign wr_en  = accept & (|nmi.wstrb);

  assign ctrl_merged = natv_pkg::byte_merge(natv_pkg::nmi_data_t'(ctrl_q), nmi.wdata, nmi.wstrb);
  assign psc_merged  = natv_pkg::byte_merge(natv_pkg::nmi_data_t'(psc_q), nmi.wdata, nmi.wstrb);
  assign cmp_merged  = natv_pkg::byte_merge(cmp_q, nmi.wdata, nmi.wstrb);

  always_comb begin
    case (nmi.addr[7:0])
      8'h00:   rd_mux = natv_pkg::nmi_data_t'(ctrl_q);
      8'h04:   rd_mux = natv_pkg::nmi_data_t'(psc_q);
      8'h08:   rd_mux = cmp_q;
      8'h0C:   rd_mux = u_tim_if.cnt;
      8'h10:   rd_mux = natv_pkg::nmi_data_t'(flag_q);
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      ctrl_q  <= '0;
      psc_q   <= '0;
      cmp_q   <= '0;
      clr_q   <= 1'b0;
      flag_q  <= 1'b0;
    end else begin
      ready_q <= accept;
      // any write to the count register clears it
      clr_q   <= wr_en && (nmi.addr[7:0] == 8'h0C);
      if (wr_en && nmi.addr[7:0] == 8'h00) begin
        ctrl_q <= ctrl_merged[1:0];
      end
      if (wr_en && nmi.addr[7:0] == 8'h04) begin
        psc_q <= psc_merged[`NATV_PSC_W-1:0];
      end
      if (wr_en && nmi.addr[7:0] == 8'h08) begin
        cmp_q <= cmp_merged;
      end
      // a match in the same cycle wins over write-one-to-clear
      if (u_tim_if.match) begin
        flag_q <= 1'b1;
      end else if (wr_en && nmi.addr[7:0] == 8'h10 && nmi.wstrb[0] && nmi.wdata[0]) begin
        flag_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_mux;
    end
  end

  assign u_tim_if.ctrl = ctrl_q;
  assign u_tim_if.psc  = psc_q;
  assign u_tim_if.cmp  = cmp_q;
  assign u_tim_if.clr  = clr_q;

  timer_core u_timer_core (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .tim    (u_tim_if)
  );

  assign nmi.ready = ready_q;
  assign nmi.rdata = rdata_q;
  assign irq_o     = flag_q & ctrl_q.irq_en;

endmodule

`default_nettype wire

//--- logic/simple_gpio.sv
// --------------------------------------------------
// gpio slave: direction, output and synchronized input
// registers at offsets 0x00, 0x04 and 0x08
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "natv_params.svh"

module simple_gpio (
  input  logic                    clk_i,
  input  logic                    reset_i,
  nmi_if.slave                    nmi,
  input  logic [`NATV_GPIO_W-1:0] gpio_in_i,
  output logic [`NATV_GPIO_W-1:0] gpio_out_o,
  output logic [`NATV_GPIO_W-1:0] gpio_oe_o
);

  localparam int GW = `NATV_GPIO_W;

  logic [GW-1:0]       dir_q;
  logic [GW-1:0]       out_q;
  logic [GW-1:0]       sync1_q;
  logic [GW-1:0]       sync2_q;
  logic                ready_q;
  logic                accept;
  logic                wr_en;
  natv_pkg::nmi_data_t rdata_q;
  natv_pkg::nmi_data_t rd_mux;
  natv_pkg::nmi_data_t dir_merged;
  natv_pkg::nmi_data_t out_merged;

  // first cycle of a valid that is not yet acknowledged
  assign accept = nmi.valid & ~ready_q;
  assign wr_en  = accept & (|nmi.wstrb);

  assign dir_merged = natv_pkg::byte_merge(natv_pkg::nmi_data_t'(dir_q), nmi.wdata, nmi.wstrb);
  assign out_merged = natv_pkg::byte_merge(natv_pkg::nmi_data_t'(out_q), nmi.wdata, nmi.wstrb);

  always_comb begin
    case (nmi.addr[7:0])
      8'h00:   rd_mux = natv_pkg::nmi_data_t'(dir_q);
      8'h04:   rd_mux = natv_pkg::nmi_data_t'(out_q);
      8'h08:   rd_mux = natv_pkg::nmi_data_t'(sync2_q);
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      dir_q   <= '0;
      out_q   <= '0;
    end else begin
      ready_q <= accept;
      if (wr_en && nmi.addr[7:0] == 8'h00) begin
        dir_q <= dir_merged[GW-1:0];
      end
      if (wr_en && nmi.addr[7:0] == 8'h04) begin
        out_q <= out_merged[GW-1:0];
      end
    end
  end

  // read data is captured alongside ready
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_mux;
    end
  end

  // two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    sync1_q <= gpio_in_i;
    sync2_q <= sync1_q;
  end

  assign nmi.ready  = ready_q;
  assign nmi.rdata  = rdata_q;
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

`default_nettype wire

//--- logic/ip_natv_wrapper.sv
// --------------------------------------------------
// decodes the register page into per-slave valids and
// merges ready and rdata back onto the upstream port
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "natv_params.svh"

module ip_natv_wrapper (
  input  logic                    clk_i,
  input  logic                    reset_i,
  nmi_if.slave                    nmi,
  input  logic [`NATV_GPIO_W-1:0] gpio_in_i,
  output logic [`NATV_GPIO_W-1:0] gpio_out_o,
  output logic [`NATV_GPIO_W-1:0] gpio_oe_o,
  output logic [1:0]              irq_o
);

  nmi_if u_gpio_nmi_if ();
  nmi_if u_tim0_nmi_if ();
  nmi_if u_tim1_nmi_if ();

  logic reg_page;
  logic gpio_ack;
  logic tim0_ack;
  logic tim1_ack;

  assign reg_page = (nmi.addr[31:24] == `NATV_REG_PAGE);

  assign u_gpio_nmi_if.valid = nmi.valid && reg_page && (nmi.addr[15:8] == `NATV_GPIO_SLOT);
  assign u_gpio_nmi_if.addr  = nmi.addr;
  assign u_gpio_nmi_if.wdata = nmi.wdata;
  assign u_gpio_nmi_if.wstrb = nmi.wstrb;

  assign u_tim0_nmi_if.valid = nmi.valid && reg_page && (nmi.addr[15:8] == `NATV_TIM0_SLOT);
  assign u_tim0_nmi_if.addr  = nmi.addr;
  assign u_tim0_nmi_if.wdata = nmi.wdata;
  assign u_tim0_nmi_if.wstrb = nmi.wstrb;

  assign u_tim1_nmi_if.valid = nmi.valid && reg_page && (nmi.addr[15:8] == `NATV_TIM1_SLOT);
  assign u_tim1_nmi_if.addr  = nmi.addr;
  assign u_tim1_nmi_if.wdata = nmi.wdata;
  assign u_tim1_nmi_if.wstrb = nmi.wstrb;

  // a slave only answers while it is the one selected
  assign gpio_ack = u_gpio_nmi_if.valid & u_gpio_nmi_if.ready;
  assign tim0_ack = u_tim0_nmi_if.valid & u_tim0_nmi_if.ready;
  assign tim1_ack = u_tim1_nmi_if.valid & u_tim1_nmi_if.ready;

  assign nmi.ready = gpio_ack | tim0_ack | tim1_ack;

  assign nmi.rdata = ({`NATV_DATA_W{gpio_ack}} & u_gpio_nmi_if.rdata) |
                     ({`NATV_DATA_W{tim0_ack}} & u_tim0_nmi_if.rdata) |
                     ({`NATV_DATA_W{tim1_ack}} & u_tim1_nmi_if.rdata);

  simple_gpio u_simple_gpio (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .nmi       (u_gpio_nmi_if),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  simple_timer u_simple_timer0 (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .nmi    (u_tim0_nmi_if),
    .irq_o  (irq_o[0])
  );

  simple_timer u_simple_timer1 (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .nmi    (u_tim1_nmi_if),
    .irq_o  (irq_o[1])
  );

endmodule

`default_nettype wire

//--- logic/natv_periph_top.sv
// --------------------------------------------------
// plain-port top of the peripheral slice, bundles the
// cpu-side bus into nmi_if for the wrapper
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "natv_params.svh"

module natv_periph_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // cpu side bus
  input  logic                    bus_valid_i,
  input  natv_pkg::nmi_addr_t     bus_addr_i,
  input  natv_pkg::nmi_data_t     bus_wdata_i,
  input  natv_pkg::nmi_strb_t     bus_wstrb_i,
  output logic                    bus_ready_o,
  output natv_pkg::nmi_data_t     bus_rdata_o,
  // pins
  input  logic [`NATV_GPIO_W-1:0] gpio_in_i,
  output logic [`NATV_GPIO_W-1:0] gpio_out_o,
  output logic [`NATV_GPIO_W-1:0] gpio_oe_o,
  output logic [1:0]              irq_o
);

  nmi_if u_nmi_if ();

  assign u_nmi_if.valid = bus_valid_i;
  assign u_nmi_if.addr  = bus_addr_i;
  assign u_nmi_if.wdata = bus_wdata_i;
  assign u_nmi_if.wstrb = bus_wstrb_i;

  assign bus_ready_o = u_nmi_if.ready;
  assign bus_rdata_o = u_nmi_if.rdata;

  ip_natv_wrapper u_ip_natv_wrapper (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .nmi       (u_nmi_if),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_o     (irq_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_natv.sv
// --------------------------------------------------
// self-checking testbench for natv_periph_top, drives the
// cpu bus and compares reads and pins with a shadow model
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "natv_params.svh"

module tb_natv;

  // about 400 accesses of ~3.5 cycles plus four timer waits of up to 256 clocks
  localparam int TIMEOUT_CYCLES = 20000;

  logic                    clk_i;
  logic                    reset_i;
  logic                    bus_valid_i;
  natv_pkg::nmi_addr_t     bus_addr_i;
  natv_pkg::nmi_data_t     bus_wdata_i;
  natv_pkg::nmi_strb_t     bus_wstrb_i;
  logic                    bus_ready_o;
  natv_pkg::nmi_data_t     bus_rdata_o;
  logic [`NATV_GPIO_W-1:0] gpio_in_i;
  logic [`NATV_GPIO_W-1:0] gpio_out_o;
  logic [`NATV_GPIO_W-1:0] gpio_oe_o;
  logic [1:0]              irq_o;

  integer      seed;
  int          cycle_cnt = 0;
  int          access_cnt = 0;
  int          ready_cnt = 0;
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];
  string       cmp_name;
  logic [31:0] cmp_exp;
  logic [31:0] cmp_act;

  // shadow of the writable registers, timers indexed by number
  logic [31:0] sh_dir;
  logic [31:0] sh_out;
  logic [31:0] sh_in;
  logic [31:0] sh_ctrl [2];
  logic [31:0] sh_psc [2];
  logic [31:0] sh_cmp [2];

  natv_periph_top dut0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .bus_valid_i(bus_valid_i),
    .bus_addr_i (bus_addr_i),
    .bus_wdata_i(bus_wdata_i),
    .bus_wstrb_i(bus_wstrb_i),
    .bus_ready_o(bus_ready_o),
    .bus_rdata_o(bus_rdata_o),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // register contents after a strobed write, cut to the field width
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_v, input logic [31:0] wdata,
                                              input logic [3:0] wstrb, input int width);
    logic [31:0] res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (wstrb[i]) begin
        res[i*8+:8] = wdata[i*8+:8];
      end
    end
    if (width < 32) begin
      res = res & ((32'd1 << width) - 32'd1);
    end
    return res;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [7:0] slot, input logic [7:0] offs);
    return {`NATV_REG_PAGE, 8'h00, slot, offs};
  endfunction

  function automatic logic [7:0] tim_slot(input int t);
    return (t == 0) ? `NATV_TIM0_SLOT : `NATV_TIM1_SLOT;
  endfunction

  // expected read value of a register from the shadow model
  function automatic logic [31:0] exp_read(input logic [31:0] addr);
    int t;
    t = (addr[15:8] == `NATV_TIM1_SLOT) ? 1 : 0;
    if (addr[15:8] == `NATV_GPIO_SLOT) begin
      case (addr[7:0])
        8'h00:   return sh_dir;
        8'h04:   return sh_out;
        8'h08:   return sh_in;
        default: return 32'd0;
      endcase
    end
    case (addr[7:0])
      8'h00:   return sh_ctrl[t];
      8'h04:   return sh_psc[t];
      8'h08:   return sh_cmp[t];
      // count and status only have a fixed value after reset
      default: return 32'd0;
    endcase
  endfunction

  task automatic expect_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
  endtask

  // compare process, drains the queued checks once per clock
  always @(negedge clk_i) begin
    while (act_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      assert (cmp_act === cmp_exp) else begin
        stop_run($sformatf("MISMATCH at %0t: %s expected 0x%h, actual 0x%h",
                           $time, cmp_name, cmp_exp, cmp_act));
      end
    end
  end

  // handshake monitor
  always @(negedge clk_i) begin
    if (!reset_i) begin
      assert (!(bus_ready_o && !bus_valid_i)) else begin
        stop_run("bus_ready_o was high while bus_valid_i was low");
      end
      if (bus_ready_o) begin
        ready_cnt++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk_i);
    bus_valid_i <= 1'b1;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    bus_wstrb_i <= wstrb;
    @(negedge clk_i);
    while (bus_ready_o !== 1'b1) begin
      if (waited >= 4) begin
        stop_run($sformatf("no ready for the access to 0x%h within 4 cycles", addr));
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
    rdata = bus_rdata_o;
    access_cnt++;
    @(posedge clk_i);
    bus_valid_i <= 1'b0;
    bus_wstrb_i <= '0;
  endtask

  task automatic check_read(input logic [31:0] addr, input logic [31:0] exp_v);
    logic [31:0] rd;
    bus_access(addr, 32'd0, 4'h0, rd);
    expect_val($sformatf("bus_rdata_o @0x%h", addr), exp_v, rd);
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    logic [31:0] unused;
    int          t;
    t = (addr[15:8] == `NATV_TIM1_SLOT) ? 1 : 0;
    bus_access(addr, wdata, wstrb, unused);
    if (addr[15:8] == `NATV_GPIO_SLOT) begin
      case (addr[7:0])
        8'h00:   sh_dir = merge_bytes(sh_dir, wdata, wstrb, `NATV_GPIO_W);
        8'h04:   sh_out = merge_bytes(sh_out, wdata, wstrb, `NATV_GPIO_W);
        default: ;
      endcase
    end else begin
      case (addr[7:0])
        8'h00:   sh_ctrl[t] = merge_bytes(sh_ctrl[t], wdata, wstrb, 2);
        8'h04:   sh_psc[t] = merge_bytes(sh_psc[t], wdata, wstrb, `NATV_PSC_W);
        8'h08:   sh_cmp[t] = merge_bytes(sh_cmp[t], wdata, wstrb, 32);
        default: ;
      endcase
    end
  endtask

  task automatic check_reset();
    @(negedge clk_i);
    expect_val("bus_ready_o", 32'd0, {31'd0, bus_ready_o});
    expect_val("gpio_out_o", 32'd0, 32'(gpio_out_o));
    expect_val("gpio_oe_o", 32'd0, 32'(gpio_oe_o));
    expect_val("irq_o", 32'd0, 32'(irq_o));
    for (int i = 0; i < 3; i++) begin
      check_read(reg_addr(`NATV_GPIO_SLOT, 8'(i * 4)), 32'd0);
    end
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 5; i++) begin
        check_read(reg_addr(tim_slot(t), 8'(i * 4)), 32'd0);
      end
    end
  endtask

  task automatic gpio_rw();
    logic [31:0] rnd;
    logic [31:0] wdata;
    logic [31:0] addr;
    logic [3:0]  strb;
    for (int i = 0; i < 100; i++) begin
      rnd   = $random(seed);
      wdata = $random(seed);
      addr  = reg_addr(`NATV_GPIO_SLOT, rnd[4] ? 8'h04 : 8'h00);
      // an all-zero strobe would turn the write into a read
      strb  = (rnd[3:0] == 4'h0) ? 4'hf : rnd[3:0];
      reg_write(addr, wdata, strb);
      check_read(addr, exp_read(addr));
      @(negedge clk_i);
      expect_val("gpio_oe_o", sh_dir, 32'(gpio_oe_o));
      expect_val("gpio_out_o", sh_out, 32'(gpio_out_o));
    end
  endtask

  task automatic gpio_input();
    logic [31:0] rnd;
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      @(posedge clk_i);
      gpio_in_i <= rnd[`NATV_GPIO_W-1:0];
      sh_in = 32'(rnd[`NATV_GPIO_W-1:0]);
      repeat (3) @(posedge clk_i);
      check_read(reg_addr(`NATV_GPIO_SLOT, 8'h08), exp_read(reg_addr(`NATV_GPIO_SLOT, 8'h08)));
    end
  endtask

  task automatic timer_match(input int t);
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [7:0]  slot;
    int          waited;
    slot = tim_slot(t);
    rnd  = $random(seed);
    reg_write(reg_addr(slot, 8'h04), {30'd0, rnd[1:0]}, 4'hf);
    reg_write(reg_addr(slot, 8'h08), {26'd0, (rnd[13:8] == 6'd0) ? 6'd1 : rnd[13:8]}, 4'hf);
    check_read(reg_addr(slot, 8'h04), exp_read(reg_addr(slot, 8'h04)));
    check_read(reg_addr(slot, 8'h08), exp_read(reg_addr(slot, 8'h08)));
    reg_write(reg_addr(slot, 8'h0c), 32'd0, 4'hf);
    reg_write(reg_addr(slot, 8'h00), 32'd3, 4'h1);
    // first match needs (psc+1)*(cmp+1) clocks, at most 4*64
    waited = 0;
    while (irq_o[t] !== 1'b1) begin
      if (waited > 4 * 64 + 8) begin
        stop_run($sformatf("irq_o[%0d] did not rise within %0d cycles", t, waited));
      end else begin
        @(negedge clk_i);
        expect_val("irq_o of the idle timer", 32'd0, {31'd0, irq_o[1-t]});
        waited++;
      end
    end
    check_read(reg_addr(slot, 8'h10), 32'd1);
    bus_access(reg_addr(slot, 8'h0c), 32'd0, 4'h0, rd);
    assert (rd <= sh_cmp[t]) else begin
      stop_run($sformatf("MISMATCH at %0t: timer %0d count expected <= %0d, actual %0d",
                         $time, t, sh_cmp[t], rd));
    end
    // freeze the counter but keep irq enable, so the clear shows on the pin
    reg_write(reg_addr(slot, 8'h00), 32'd2, 4'h1);
    @(negedge clk_i);
    expect_val("irq_o before status clear", 32'd1, {31'd0, irq_o[t]});
    reg_write(reg_addr(slot, 8'h10), 32'd1, 4'h1);
    @(negedge clk_i);
    expect_val("irq_o after status clear", 32'd0, {31'd0, irq_o[t]});
    check_read(reg_addr(slot, 8'h10), 32'd0);
    // irq enable off, flag must still set
    reg_write(reg_addr(slot, 8'h00), 32'd1, 4'h1);
    waited = 0;
    rd = 32'd0;
    while (rd !== 32'd1) begin
      if (waited > 100) begin
        stop_run($sformatf("timer %0d status never set with irq enable off", t));
      end else begin
        bus_access(reg_addr(slot, 8'h10), 32'd0, 4'h0, rd);
        @(negedge clk_i);
        expect_val("irq_o with irq enable off", 32'd0, {31'd0, irq_o[t]});
        waited++;
      end
    end
    reg_write(reg_addr(slot, 8'h00), 32'd0, 4'h1);
    reg_write(reg_addr(slot, 8'h10), 32'd1, 4'h1);
    check_read(reg_addr(slot, 8'h10), 32'd0);
  endtask

  task automatic count_control(input int t);
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] wdata;
    logic [7:0]  slot;
    slot = tim_slot(t);
    // a far compare keeps the count from wrapping back to zero
    reg_write(reg_addr(slot, 8'h08), 32'hffff_ffff, 4'hf);
    // let the count move off zero, then freeze it
    reg_write(reg_addr(slot, 8'h00), 32'd1, 4'h1);
    repeat (7) @(posedge clk_i);
    reg_write(reg_addr(slot, 8'h00), 32'd0, 4'h1);
    check_read(reg_addr(slot, 8'h00), exp_read(reg_addr(slot, 8'h00)));
    bus_access(reg_addr(slot, 8'h0c), 32'd0, 4'h0, first);
    assert (first !== 32'd0) else begin
      stop_run($sformatf("timer %0d count did not move while it was enabled", t));
    end
    repeat (5) @(posedge clk_i);
    bus_access(reg_addr(slot, 8'h0c), 32'd0, 4'h0, second);
    expect_val("timer count while disabled", first, second);
    wdata = $random(seed);
    reg_write(reg_addr(slot, 8'h0c), wdata, 4'hf);
    check_read(reg_addr(slot, 8'h0c), 32'd0);
    // a match may have set the flag while the count ran
    reg_write(reg_addr(slot, 8'h10), 32'd1, 4'h1);
  endtask

  initial begin
    seed        = 32'h3a3f_f129;
    reset_i     = 1'b1;
    bus_valid_i = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    bus_wstrb_i = '0;
    gpio_in_i   = '0;
    sh_dir      = 32'd0;
    sh_out      = 32'd0;
    sh_in       = 32'd0;
    sh_ctrl     = '{32'd0, 32'd0};
    sh_psc      = '{32'd0, 32'd0};
    sh_cmp      = '{32'd0, 32'd0};
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    check_reset();
    gpio_rw();
    gpio_input();
    for (int t = 0; t < 2; t++) begin
      timer_match(t);
      count_control(t);
    end
    repeat (2) @(negedge clk_i);
    expect_val("bus_ready_o pulse count", access_cnt, ready_cnt);
    repeat (2) @(negedge clk_i);
    if (act_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_run("checks were still queued at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/natv_pkg.sv
logic/nmi_if.sv
logic/tim_if.sv
logic/timer_core.sv
logic/simple_timer.sv
logic/simple_gpio.sv
logic/ip_natv_wrapper.sv
logic/natv_periph_top.sv
bench/tb_natv.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_natv -o tb_natv \
  > sim.log 2>&1 \
  && ./obj_dir/tb_natv >> sim.log 2>&1

grep -qx "Testbench passed" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed, see sim.log"; exit 1; }
